/* hw/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Byte address width of the memory system
`define ADDR_BITS 32

// One cache line is 32 bytes
`define LINE_BITS 256
`define OFFSET_BITS 5

`endif

/* hw/cache_pkg.sv */
package cache_pkg;

    // Eviction buffer: idle, serving a fill, writing back the held line
    typedef enum logic [1:0] {EB_IDLE, EB_READ, EB_WB} eb_state_t;

    // Client port handshake progress
    typedef enum logic [1:0] {PORT_IDLE, PORT_BUSY, PORT_DONE} port_state_t;

    // Memory arbiter: waiting for a source, request out, waiting for ack to fall
    typedef enum logic [1:0] {ARB_IDLE, ARB_REQ, ARB_RELEASE} arb_state_t;

    // Client line operation
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_EVICT = 1'b1
    } line_op_t;

endpackage

/* hw/line_request_port.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module line_request_port
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  client_req,
    input  line_op_t              client_op,
    input  logic [`ADDR_BITS-1:0] client_address,
    input  logic [`LINE_BITS-1:0] client_wdata,
    output logic                  client_ack,
    output logic [`LINE_BITS-1:0] client_rdata,
    output logic                  cache_read,
    output logic                  cache_write,
    output logic [`ADDR_BITS-1:0] cache_address,
    output logic [`LINE_BITS-1:0] cache_wdata,
    input  logic [`LINE_BITS-1:0] cache_rdata,
    input  logic                  cache_resp
);

    port_state_t           state;
    port_state_t           next_state;
    line_op_t              op_q;
    logic [`ADDR_BITS-1:0] addr_q;
    logic [`LINE_BITS-1:0] line_q;

    always_comb begin
        next_state = state;
        case (state)
            PORT_IDLE: begin
                if (client_req) begin
                    next_state = PORT_BUSY;
                end
            end
            PORT_BUSY: begin
                if (cache_resp) begin
                    next_state = PORT_DONE;
                end
            end
            PORT_DONE: begin
                // Hold ack until the client lets go of req
                if (!client_req) begin
                    next_state = PORT_IDLE;
                end
            end
            default: next_state = PORT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= PORT_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == PORT_IDLE && client_req) begin
            op_q   <= client_op;
            addr_q <= client_address;
            line_q <= client_wdata;
        end
        if (state == PORT_BUSY && cache_resp && op_q == OP_READ) begin
            client_rdata <= cache_rdata;
        end
    end

    // The level request is up for the whole busy phase and drops after resp
    assign cache_read    = (state == PORT_BUSY) && (op_q == OP_READ);
    assign cache_write   = (state == PORT_BUSY) && (op_q == OP_EVICT);
    assign cache_address = addr_q;
    assign cache_wdata   = line_q;
    assign client_ack    = (state == PORT_DONE);

endmodule

/* hw/eviction_buffer.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module eviction_buffer
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ADDR_BITS-1:0] cache_address,
    input  logic                  cache_read,
    input  logic                  cache_write,
    input  logic [`LINE_BITS-1:0] cache_wdata,
    output logic [`LINE_BITS-1:0] cache_rdata,
    output logic                  cache_resp,
    input  logic [`LINE_BITS-1:0] arb_rdata,
    input  logic                  arb_resp,
    output logic                  arb_read,
    output logic                  arb_write,
    output logic [`ADDR_BITS-1:0] arb_address,
    output logic [`LINE_BITS-1:0] arb_wdata
);

    eb_state_t             state;
    eb_state_t             next_state;
    logic [`ADDR_BITS-1:0] wb_address;
    logic [`LINE_BITS-1:0] wb_line;
    logic                  wb_pending;

    always_comb begin
        cache_resp = 1'b0;
        arb_read   = 1'b0;
        arb_write  = 1'b0;
        case (state)
            EB_IDLE: begin
                // Evictions are taken at once, the line simply parks here
                cache_resp = cache_write;
            end
            EB_READ: begin
                arb_read   = 1'b1;
                cache_resp = arb_resp;
            end
            EB_WB: begin
                arb_write = 1'b1;
            end
            default: ;
        endcase
    end

    assign cache_rdata = arb_rdata;
    assign arb_address = (state == EB_WB) ? wb_address : cache_address;
    assign arb_wdata   = wb_line;

    always_comb begin
        next_state = state;
        case (state)
            EB_IDLE: begin
                if (cache_read) begin
                    next_state = EB_READ;
                end
            end
            EB_READ: begin
                // The fill goes first and the victim follows it
                if (arb_resp) begin
                    next_state = wb_pending ? EB_WB : EB_IDLE;
                end
            end
            EB_WB: begin
                if (arb_resp) begin
                    next_state = EB_IDLE;
                end
            end
            default: next_state = EB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= EB_IDLE;
            wb_pending <= 1'b0;
        end else begin
            state <= next_state;
            if (state == EB_IDLE && cache_write) begin
                wb_pending <= 1'b1;
            end else if (state == EB_WB && arb_resp) begin
                wb_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == EB_IDLE && cache_write) begin
            wb_address <= cache_address;
            wb_line    <= cache_wdata;
        end
    end

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module mem_arbiter
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  arb_read,
    input  logic                  arb_write,
    input  logic [`ADDR_BITS-1:0] arb_address,
    input  logic [`LINE_BITS-1:0] arb_wdata,
    output logic [`LINE_BITS-1:0] arb_rdata,
    output logic                  arb_resp,
    input  logic                  ifetch_req,
    input  logic [`ADDR_BITS-1:0] ifetch_address,
    output logic                  ifetch_ack,
    output logic [`LINE_BITS-1:0] ifetch_rdata,
    output logic                  mem_req,
    output logic                  mem_write,
    output logic [`ADDR_BITS-1:0] mem_address,
    output logic [`LINE_BITS-1:0] mem_wdata,
    input  logic                  mem_ack,
    input  logic [`LINE_BITS-1:0] mem_rdata
);

    arb_state_t state;
    logic       grant_if;
    logic       eb_wants;
    logic       if_wants;
    logic       pick_if;

    assign eb_wants = arb_read | arb_write;
    // Fetch may not ask again until its previous ack has been released
    assign if_wants = ifetch_req & ~ifetch_ack;
    // grant_if keeps the last grant, so the other side wins a tie
    assign pick_if  = if_wants & (~eb_wants | ~grant_if);

    assign mem_req   = (state == ARB_REQ);
    assign arb_rdata = mem_rdata;
    assign arb_resp  = (state == ARB_REQ) && mem_ack && !grant_if;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ARB_IDLE;
            grant_if   <= 1'b0;
            mem_write  <= 1'b0;
            ifetch_ack <= 1'b0;
        end else begin
            if (ifetch_ack && !ifetch_req) begin
                ifetch_ack <= 1'b0;
            end
            case (state)
                ARB_IDLE: begin
                    if (eb_wants || if_wants) begin
                        state     <= ARB_REQ;
                        grant_if  <= pick_if;
                        mem_write <= !pick_if && arb_write;
                    end
                end
                ARB_REQ: begin
                    if (mem_ack) begin
                        state     <= ARB_RELEASE;
                        mem_write <= 1'b0;
                        if (grant_if) begin
                            ifetch_ack <= 1'b1;
                        end
                    end
                end
                ARB_RELEASE: begin
                    if (!mem_ack) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && (eb_wants || if_wants)) begin
            mem_address <= pick_if ? ifetch_address : arb_address;
            mem_wdata   <= arb_wdata;
        end
        if (state == ARB_REQ && mem_ack && grant_if) begin
            ifetch_rdata <= mem_rdata;
        end
    end

endmodule

/* hw/mem_subsys.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module mem_subsys
    import cache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  client_req,
    input  line_op_t              client_op,
    input  logic [`ADDR_BITS-1:0] client_address,
    input  logic [`LINE_BITS-1:0] client_wdata,
    output logic                  client_ack,
    output logic [`LINE_BITS-1:0] client_rdata,
    input  logic                  ifetch_req,
    input  logic [`ADDR_BITS-1:0] ifetch_address,
    output logic                  ifetch_ack,
    output logic [`LINE_BITS-1:0] ifetch_rdata,
    output logic                  mem_req,
    output logic                  mem_write,
    output logic [`ADDR_BITS-1:0] mem_address,
    output logic [`LINE_BITS-1:0] mem_wdata,
    input  logic                  mem_ack,
    input  logic [`LINE_BITS-1:0] mem_rdata
);

    // Port to eviction buffer
    logic                  cache_read;
    logic                  cache_write;
    logic [`ADDR_BITS-1:0] cache_address;
    logic [`LINE_BITS-1:0] cache_wdata;
    logic [`LINE_BITS-1:0] cache_rdata;
    logic                  cache_resp;

    // Eviction buffer to arbiter
    logic                  arb_read;
    logic                  arb_write;
    logic [`ADDR_BITS-1:0] arb_address;
    logic [`LINE_BITS-1:0] arb_wdata;
    logic [`LINE_BITS-1:0] arb_rdata;
    logic                  arb_resp;

    line_request_port u_line_request_port (
        .clk            (clk),
        .rst            (rst),
        .client_req     (client_req),
        .client_op      (client_op),
        .client_address (client_address),
        .client_wdata   (client_wdata),
        .client_ack     (client_ack),
        .client_rdata   (client_rdata),
        .cache_read     (cache_read),
        .cache_write    (cache_write),
        .cache_address  (cache_address),
        .cache_wdata    (cache_wdata),
        .cache_rdata    (cache_rdata),
        .cache_resp     (cache_resp)
    );

    eviction_buffer u_eviction_buffer (
        .clk           (clk),
        .rst           (rst),
        .cache_address (cache_address),
        .cache_read    (cache_read),
        .cache_write   (cache_write),
        .cache_wdata   (cache_wdata),
        .cache_rdata   (cache_rdata),
        .cache_resp    (cache_resp),
        .arb_rdata     (arb_rdata),
        .arb_resp      (arb_resp),
        .arb_read      (arb_read),
        .arb_write     (arb_write),
        .arb_address   (arb_address),
        .arb_wdata     (arb_wdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk            (clk),
        .rst            (rst),
        .arb_read       (arb_read),
        .arb_write      (arb_write),
        .arb_address    (arb_address),
        .arb_wdata      (arb_wdata),
        .arb_rdata      (arb_rdata),
        .arb_resp       (arb_resp),
        .ifetch_req     (ifetch_req),
        .ifetch_address (ifetch_address),
        .ifetch_ack     (ifetch_ack),
        .ifetch_rdata   (ifetch_rdata),
        .mem_req        (mem_req),
        .mem_write      (mem_write),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata),
        .mem_ack        (mem_ack),
        .mem_rdata      (mem_rdata)
    );

endmodule

/* verification/mem_subsys_sva.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module mem_subsys_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  client_req,
    input logic                  client_ack,
    input logic                  mem_req,
    input logic                  mem_ack,
    input logic                  mem_write,
    input logic [`ADDR_BITS-1:0] mem_address,
    input logic [`LINE_BITS-1:0] mem_wdata,
    input logic                  arb_resp
);

    // The arbiter is the requester on the memory port
    req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
        else $error("mem_req dropped before mem_ack");

    cmd_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> $stable(mem_write) && $stable(mem_address)
                                && $stable(mem_wdata))
        else $error("memory command changed while mem_req was high");

    // The client may release req as soon as it sees ack, so look at the edge that raised ack
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(client_ack) |-> $past(client_req))
        else $error("client_ack rose without client_req");

    // arb_resp is a single-cycle strobe
    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        arb_resp |=> !arb_resp)
        else $error("arb_resp held longer than one cycle");

endmodule

bind mem_subsys mem_subsys_sva u_mem_subsys_sva (
    .clk         (clk),
    .rst         (rst),
    .client_req  (client_req),
    .client_ack  (client_ack),
    .mem_req     (mem_req),
    .mem_ack     (mem_ack),
    .mem_write   (mem_write),
    .mem_address (mem_address),
    .mem_wdata   (mem_wdata),
    .arb_resp    (arb_resp)
);

/* verification/mem_subsys_tb.sv */
`timescale 1ns/1ps
`include "cache_defs.svh"

module mem_subsys_tb
    import cache_pkg::*;
();

    typedef struct packed {
        logic                  write;
        logic [`ADDR_BITS-1:0] address;
        logic [`LINE_BITS-1:0] line;
    } mem_op_t;

    // Lines 48 to 63 hold instructions and are only ever fetched
    localparam logic [5:0] IF_FIRST = 6'd48;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  client_req;
    line_op_t              client_op;
    logic [`ADDR_BITS-1:0] client_address;
    logic [`LINE_BITS-1:0] client_wdata;
    logic                  client_ack;
    logic [`LINE_BITS-1:0] client_rdata;
    logic                  ifetch_req;
    logic [`ADDR_BITS-1:0] ifetch_address;
    logic                  ifetch_ack;
    logic [`LINE_BITS-1:0] ifetch_rdata;
    logic                  mem_req;
    logic                  mem_write;
    logic [`ADDR_BITS-1:0] mem_address;
    logic [`LINE_BITS-1:0] mem_wdata;
    logic                  mem_ack;
    logic [`LINE_BITS-1:0] mem_rdata;

    integer                seed = 32'h2a21_63d9;
    int                    errors = 0;
    int                    if_issued = 0;
    int                    if_reads = 0;
    logic [`LINE_BITS-1:0] mem [0:63];
    logic [`LINE_BITS-1:0] shadow [0:63];
    mem_op_t               expect_q [$];
    logic                  evict_pending = 1'b0;
    logic [`ADDR_BITS-1:0] evict_addr;
    logic [`LINE_BITS-1:0] evict_line;

    // Stimulus table
    line_op_t              tbl_op [$];
    logic [`ADDR_BITS-1:0] tbl_addr [$];
    logic [31:0]           tbl_word [$];
    logic                  tbl_if_en [$];
    logic [`ADDR_BITS-1:0] tbl_if_addr [$];

    always #2 clk = ~clk;

    mem_subsys u_mem_subsys (
        .clk            (clk),
        .rst            (rst),
        .client_req     (client_req),
        .client_op      (client_op),
        .client_address (client_address),
        .client_wdata   (client_wdata),
        .client_ack     (client_ack),
        .client_rdata   (client_rdata),
        .ifetch_req     (ifetch_req),
        .ifetch_address (ifetch_address),
        .ifetch_ack     (ifetch_ack),
        .ifetch_rdata   (ifetch_rdata),
        .mem_req        (mem_req),
        .mem_write      (mem_write),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata),
        .mem_ack        (mem_ack),
        .mem_rdata      (mem_rdata)
    );

    function automatic logic [5:0] line_of(input logic [`ADDR_BITS-1:0] address);
        return address[`OFFSET_BITS +: 6];
    endfunction

    function automatic logic [`LINE_BITS-1:0] make_line(input logic [31:0] word);
        logic [`LINE_BITS-1:0] line;
        line = '0;
        for (int k = 0; k < 8; k++) begin
            line = {line[`LINE_BITS-33:0], word ^ (32'h0101_0101 * k)};
        end
        return line;
    endfunction

    task automatic add_entry(input line_op_t op, input logic [`ADDR_BITS-1:0] address,
                             input logic [31:0] word, input logic if_en,
                             input logic [`ADDR_BITS-1:0] if_address);
        tbl_op.push_back(op);
        tbl_addr.push_back(address);
        tbl_word.push_back(word);
        tbl_if_en.push_back(if_en);
        tbl_if_addr.push_back(if_address);
    endtask

    task automatic report_mismatch(input string name, input logic [`LINE_BITS-1:0] expected,
                                   input logic [`LINE_BITS-1:0] actual);
        errors = errors + 1;
        $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors = errors + 1;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic run_client(input int n);
        logic [5:0]            li;
        logic [`LINE_BITS-1:0] expected;
        logic                  eb_idle;
        int                    cycles;
        mem_op_t               op;
        li = line_of(tbl_addr[n]);
        client_op      = tbl_op[n];
        client_address = tbl_addr[n];
        client_wdata   = make_line(tbl_word[n]);
        expected       = shadow[li];
        eb_idle        = (u_mem_subsys.u_eviction_buffer.state == EB_IDLE);
        if (tbl_op[n] == OP_EVICT) begin
            // The victim reaches memory only after the next fill
            shadow[li]    = client_wdata;
            evict_pending = 1'b1;
            evict_addr    = tbl_addr[n];
            evict_line    = client_wdata;
        end else begin
            op.write   = 1'b0;
            op.address = tbl_addr[n];
            op.line    = '0;
            expect_q.push_back(op);
            if (evict_pending) begin
                op.write   = 1'b1;
                op.address = evict_addr;
                op.line    = evict_line;
                expect_q.push_back(op);
                evict_pending = 1'b0;
            end
        end
        client_req = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles = cycles + 1;
        end while (!client_ack);
        // Latch on the first edge, the idle buffer answers in the busy cycle
        if (tbl_op[n] == OP_EVICT && eb_idle && cycles != 2) begin
            report_failure($sformatf("eviction ack came after %0d cycles, not 2", cycles));
        end
        if (tbl_op[n] == OP_READ && client_rdata !== expected) begin
            report_mismatch("client_rdata", expected, client_rdata);
        end
        client_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (client_ack);
    endtask

    task automatic run_ifetch(input int n);
        logic [5:0] li;
        li = line_of(tbl_if_addr[n]);
        ifetch_address = tbl_if_addr[n];
        ifetch_req = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!ifetch_ack);
        if (ifetch_rdata !== shadow[li]) begin
            report_mismatch("ifetch_rdata", shadow[li], ifetch_rdata);
        end
        ifetch_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (ifetch_ack);
        if_issued = if_issued + 1;
    endtask

    // Memory model with a random answer delay of 1 to 4 cycles
    initial begin : memory_model
        int         delay;
        logic [5:0] li;
        mem_op_t    head;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req && !mem_ack) begin
                delay = 1 + ($random(seed) & 32'd3);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                li = line_of(mem_address);
                if (li >= IF_FIRST) begin
                    if (mem_write) begin
                        report_failure("memory write into the instruction region");
                    end
                    if_reads = if_reads + 1;
                end else if (expect_q.size() == 0) begin
                    report_failure("data access on the memory port with no client transfer due");
                end else begin
                    head = expect_q.pop_front();
                    if (mem_write !== head.write) begin
                        report_mismatch("mem_write", {255'd0, head.write}, {255'd0, mem_write});
                    end
                    if (mem_address !== head.address) begin
                        report_mismatch("mem_address", {224'd0, head.address},
                                        {224'd0, mem_address});
                    end
                    if (head.write && mem_wdata !== head.line) begin
                        report_mismatch("mem_wdata", head.line, mem_wdata);
                    end
                end
                if (mem_write) begin
                    mem[li] = mem_wdata;
                end else begin
                    mem_rdata = mem[li];
                end
                mem_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (mem_req);
                mem_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #1;
        repeat (tbl_op.size() * 40) @(posedge clk);
        $display("Timeout: a handshake never completed, %0d errors so far", errors);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        logic [5:0]            li;
        logic [`LINE_BITS-1:0] fill;
        int                    n;
        rst            = 1'b1;
        client_req     = 1'b0;
        client_op      = OP_READ;
        client_address = '0;
        client_wdata   = '0;
        ifetch_req     = 1'b0;
        ifetch_address = '0;

        li = '0;
        repeat (64) begin
            fill = '0;
            repeat (8) begin
                fill = {fill[`LINE_BITS-33:0], $random(seed) ^ {26'd0, li}};
            end
            mem[li]    = fill;
            shadow[li] = fill;
            li = li + 6'd1;
        end

        add_entry(OP_READ,  32'h0000_0040, 32'h0000_0000, 1'b0, 32'h0000_0000);
        add_entry(OP_EVICT, 32'h0000_0020, 32'hc0de_0001, 1'b1, 32'h0000_0600);
        add_entry(OP_READ,  32'h0000_00a0, 32'h0000_0000, 1'b1, 32'h0000_0620);
        add_entry(OP_EVICT, 32'h0000_00c0, 32'hc0de_0002, 1'b0, 32'h0000_0000);
        add_entry(OP_READ,  32'h0000_0020, 32'h0000_0000, 1'b1, 32'h0000_0640);
        add_entry(OP_EVICT, 32'h0000_0020, 32'hc0de_0003, 1'b1, 32'h0000_0660);
        add_entry(OP_READ,  32'h0000_00c0, 32'h0000_0000, 1'b1, 32'h0000_0680);
        add_entry(OP_READ,  32'h0000_0100, 32'h0000_0000, 1'b1, 32'h0000_06a0);
        add_entry(OP_EVICT, 32'h0000_0100, 32'hc0de_0004, 1'b1, 32'h0000_0600);
        add_entry(OP_READ,  32'h0000_0020, 32'h0000_0000, 1'b1, 32'h0000_07e0);
        add_entry(OP_EVICT, 32'h0000_03e0, 32'hc0de_0005, 1'b0, 32'h0000_0000);
        add_entry(OP_READ,  32'h0000_0100, 32'h0000_0000, 1'b1, 32'h0000_06c0);

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        if (client_ack !== 1'b0 || ifetch_ack !== 1'b0 || mem_req !== 1'b0) begin
            report_failure("handshake outputs not low after reset");
        end

        for (n = 0; n < tbl_op.size(); n++) begin
            fork
                run_client(n);
                if (tbl_if_en[n]) run_ifetch(n);
            join
        end

        // The last victim is still on its way to memory
        while (expect_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        if (if_reads != if_issued) begin
            report_failure($sformatf("%0d fetches issued but %0d reached memory",
                                     if_issued, if_reads));
        end

        $display("Ran %0d entries and %0d fetches, %0d errors", n, if_issued, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hw
hw/cache_pkg.sv
hw/line_request_port.sv
hw/eviction_buffer.sv
hw/mem_arbiter.sv
hw/mem_subsys.sv
verification/mem_subsys_sva.sv
verification/mem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mem_subsys testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module mem_subsys_tb
./obj_dir/Vmem_subsys_tb > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
